//--- files.f
hdl/axis_pkg.sv
hdl/ualink_pkg.sv
hdl/ingress_fifo.sv
hdl/ualink_cmd_parser.sv
hdl/cmd_ram.sv
hdl/read_responder.sv
hdl/ualink_turbo64.sv
dv/ualink_turbo64_chk.sv
dv/ualink_turbo64_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module ualink_turbo64_tb -f files.f -o sim_ualink_turbo64 \
   && ./obj_dir/sim_ualink_turbo64 > sim.log 2>&1 \
   ; cat sim.log 2>/dev/null \
   ; grep -q "Finished with no errors" sim.log 2>/dev/null \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

//--- dv/ualink_turbo64_tb.sv
// table-driven testbench; no packet reads unwritten RAM or overlaps a read still draining
`timescale 1ns/1ps

module ualink_turbo64_tb;
   import axis_pkg::*;

   localparam logic [15:0] WR_OP = 16'h0245;
   localparam logic [15:0] RD_OP = 16'h0145;
   localparam int BURST    = 8;
   localparam int TIMEOUT  = 1000; // cycles per wait
   localparam int NUM_PKTS = 11;

   typedef struct packed {
      logic [15:0] op;
      logic [7:0]  addr;
      logic [7:0]  nwords; // data beats after the header
      logic [7:0]  seed;   // selects the payload pattern
   } pkt_t;

   logic       axi_aclk;
   logic       axi_resetn;
   axis_beat_t s_axis_beat;
   logic       s_axis_tvalid;
   logic       s_axis_tready;
   axis_beat_t m_axis_beat;
   logic       m_axis_tvalid;
   logic       m_axis_tready;
   logic [63:0] model_ram [256];
   axis_beat_t exp_q [$];
   int         stalls; // ingress cycles lost to back-pressure

   pkt_t pkts [NUM_PKTS] = '{
      '{WR_OP,   8'd16,  8'd8,  8'h11}, // full burst
      '{RD_OP,   8'd16,  8'd0,  8'h00},
      '{16'h1234, 8'd40, 8'd4,  8'h22}, // five beats with the header
      '{WR_OP,   8'd252, 8'd8,  8'h33}, // wraps to 0..3
      '{RD_OP,   8'd252, 8'd0,  8'h00},
      '{WR_OP,   8'd16,  8'd3,  8'h44}, // short write
      '{RD_OP,   8'd16,  8'd0,  8'h00},
      '{16'h7700, 8'd5,  8'd24, 8'h55}, // long enough to fill the FIFO
      '{WR_OP,   8'd100, 8'd10, 8'h66}, // two beats past the burst
      '{RD_OP,   8'd100, 8'd2,  8'h77}, // payload dropped
      '{16'h0300, 8'd9,  8'd0,  8'h88}  // header only
   };

   ualink_turbo64 #(
      .FIFO_DEPTH_BITS(4)
   ) u_ualink_turbo64 (
      .axi_aclk(axi_aclk),
      .axi_resetn(axi_resetn),
      .s_axis_beat(s_axis_beat),
      .s_axis_tvalid(s_axis_tvalid),
      .s_axis_tready(s_axis_tready),
      .m_axis_beat(m_axis_beat),
      .m_axis_tvalid(m_axis_tvalid),
      .m_axis_tready(m_axis_tready)
   );

   initial begin
      axi_aclk = 1'b0;
      forever #2 axi_aclk = ~axi_aclk;
   end

   function automatic logic [63:0] data_word(input logic [7:0] seed, input int k);
      logic [7:0] idx;
      idx = 8'(k);
      return {seed, idx, ~seed, 8'hC3, seed, idx, seed ^ idx, 8'h5A};
   endfunction

   function automatic logic [63:0] header_word(input pkt_t p);
      return {p.op, 32'h0, p.seed, p.addr};
   endfunction

   task automatic abort_run(input string line);
      $display("%s", line);
      $display("Finished with errors");
      $fatal(1, "simulation stopped");
   endtask

   // walks the table through a RAM model in packet order
   task automatic build_expected();
      axis_beat_t beat;
      logic [7:0] waddr;
      int k;
      exp_q.delete();
      foreach (pkts[i]) begin
         if (pkts[i].op == WR_OP) begin
            for (k = 0; k < int'(pkts[i].nwords) && k < BURST; k++) begin
               waddr = pkts[i].addr + 8'(k); // wraps at 256
               model_ram[waddr] = data_word(pkts[i].seed, k);
            end
         end else if (pkts[i].op == RD_OP) begin
            for (k = 0; k < BURST; k++) begin
               waddr = pkts[i].addr + 8'(k);
               beat = '{data: model_ram[waddr], last: (k == BURST - 1)};
               exp_q.push_back(beat);
            end
         end else begin
            beat = '{data: header_word(pkts[i]), last: (pkts[i].nwords == 0)};
            exp_q.push_back(beat);
            for (k = 0; k < int'(pkts[i].nwords); k++) begin
               beat = '{data: data_word(pkts[i].seed, k), last: (k == int'(pkts[i].nwords) - 1)};
               exp_q.push_back(beat);
            end
         end
      end
   endtask

   // called on a falling edge and returns on the falling edge after the transfer
   task automatic send_beat(input axis_beat_t beat);
      int waited;
      waited = 0;
      s_axis_beat   = beat;
      s_axis_tvalid = 1'b1;
      while (!s_axis_tready) begin
         @(negedge axi_aclk);
         waited++;
         stalls++;
         assert (waited < TIMEOUT) else abort_run("timed out waiting for s_axis_tready");
      end
      @(negedge axi_aclk);
   endtask

   task automatic drive_packets();
      axis_beat_t beat;
      int k;
      foreach (pkts[i]) begin
         beat = '{data: header_word(pkts[i]), last: (pkts[i].nwords == 0)};
         send_beat(beat);
         for (k = 0; k < int'(pkts[i].nwords); k++) begin
            beat = '{data: data_word(pkts[i].seed, k), last: (k == int'(pkts[i].nwords) - 1)};
            send_beat(beat);
         end
      end
      s_axis_tvalid = 1'b0;
   endtask

   task automatic collect_egress(input bit random_ready);
      axis_beat_t exp_beat;
      int idle;
      int idx;
      idle = 0;
      idx  = 0;
      while (exp_q.size() > 0) begin
         @(negedge axi_aclk);
         m_axis_tready = random_ready ? 1'($urandom % 2) : 1'b1;
         if (m_axis_tvalid && m_axis_tready) begin // beat moves on the next rising edge
            exp_beat = exp_q.pop_front();
            assert (m_axis_beat == exp_beat) else abort_run($sformatf(
               "** Error @ %0d ns: egress beat %0d is %h last %0b, expected %h last %0b",
               $time, idx, m_axis_beat.data, m_axis_beat.last, exp_beat.data, exp_beat.last));
            idx++;
            idle = 0;
         end else begin
            idle++;
            assert (idle < TIMEOUT) else abort_run("timed out waiting for an egress beat");
         end
      end
   endtask

   task automatic run_pass(input bit random_ready);
      build_expected();
      stalls = 0;
      fork
         drive_packets();
         collect_egress(random_ready);
      join
   endtask

   initial begin
      void'($urandom(42239));
      axi_resetn    = 1'b0;
      s_axis_beat   = '0;
      s_axis_tvalid = 1'b0;
      m_axis_tready = 1'b1;
      stalls        = 0;
      repeat (3) @(negedge axi_aclk);
      axi_resetn = 1'b1;
      run_pass(1'b0); // egress always ready
      run_pass(1'b1); // same packets under random back-pressure
      assert (stalls > 0) else abort_run("s_axis_tready never dropped under back-pressure");
      $display("Finished with no errors");
      $finish;
   end

endmodule

//--- dv/ualink_turbo64_chk.sv
// stream protocol checks bound into ualink_turbo64; egress stability is not checked during reset
`timescale 1ns/1ps

module ualink_turbo64_chk (
   input logic                 axi_aclk,
   input logic                 axi_resetn,
   input logic                 s_axis_tvalid,
   input logic                 s_axis_tready,
   input axis_pkg::axis_beat_t m_axis_beat,
   input logic                 m_axis_tvalid,
   input logic                 m_axis_tready
);

   // a stalled egress beat holds until taken
   egress_hold: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      (m_axis_tvalid && !m_axis_tready) |=> (m_axis_tvalid && $stable(m_axis_beat)))
      else $error("egress beat changed or was dropped while stalled");

   egress_idle_after_reset: assert property (@(posedge axi_aclk)
      !axi_resetn |=> !m_axis_tvalid)
      else $error("m_axis_tvalid high in the cycle after reset");

   ingress_ready_after_reset: assert property (@(posedge axi_aclk)
      !axi_resetn |=> s_axis_tready)
      else $error("s_axis_tready low right after reset");

   // FIFO can only fill from accepted data
   ingress_ready_holds: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      (s_axis_tready && !s_axis_tvalid) |=> s_axis_tready)
      else $error("s_axis_tready dropped with no ingress data");

endmodule

bind ualink_turbo64 ualink_turbo64_chk u_chk (
   .axi_aclk(axi_aclk),
   .axi_resetn(axi_resetn),
   .s_axis_tvalid(s_axis_tvalid),
   .s_axis_tready(s_axis_tready),
   .m_axis_beat(m_axis_beat),
   .m_axis_tvalid(m_axis_tvalid),
   .m_axis_tready(m_axis_tready)
);

//--- hdl/ualink_turbo64.sv
// command endpoint top; a write queued behind a stalled read burst may reach the RAM before it is read
`timescale 1ns/1ps

module ualink_turbo64 #(
   parameter int FIFO_DEPTH_BITS = 4
) (
   input  logic                 axi_aclk,
   input  logic                 axi_resetn,
   input  axis_pkg::axis_beat_t s_axis_beat,
   input  logic                 s_axis_tvalid,
   output logic                 s_axis_tready,
   output axis_pkg::axis_beat_t m_axis_beat,
   output logic                 m_axis_tvalid,
   input  logic                 m_axis_tready
);
   import axis_pkg::*;
   import ualink_pkg::*;

   axis_beat_t fifo_beat;
   logic       fifo_valid;
   logic       fifo_pop;
   logic       nearly_full;
   axis_beat_t fwd_beat;
   logic       fwd_valid;
   logic       fwd_ready;
   rd_req_t    rd_req;
   logic       rd_req_ready;
   logic       ram_we;
   ram_addr_t  ram_waddr;
   data_t      ram_wdata;
   ram_addr_t  ram_raddr;
   data_t      ram_rdata;

   assign s_axis_tready = !nearly_full;

   ingress_fifo #(
      .FIFO_DEPTH_BITS(FIFO_DEPTH_BITS)
   ) u_fifo (
      .axi_aclk(axi_aclk),
      .axi_resetn(axi_resetn),
      .wr_beat(s_axis_beat),
      .wr_valid(s_axis_tvalid),
      .nearly_full(nearly_full),
      .rd_beat(fifo_beat),
      .rd_valid(fifo_valid),
      .rd_pop(fifo_pop)
   );

   ualink_cmd_parser u_parser (
      .axi_aclk(axi_aclk),
      .axi_resetn(axi_resetn),
      .fifo_beat(fifo_beat),
      .fifo_valid(fifo_valid),
      .fifo_pop(fifo_pop),
      .fwd_beat(fwd_beat),
      .fwd_valid(fwd_valid),
      .fwd_ready(fwd_ready),
      .rd_req(rd_req),
      .rd_req_ready(rd_req_ready),
      .ram_we(ram_we),
      .ram_waddr(ram_waddr),
      .ram_wdata(ram_wdata)
   );

   cmd_ram u_ram (
      .axi_aclk(axi_aclk),
      .we(ram_we),
      .waddr(ram_waddr),
      .wdata(ram_wdata),
      .raddr(ram_raddr),
      .rdata(ram_rdata)
   );

   read_responder u_responder (
      .axi_aclk(axi_aclk),
      .axi_resetn(axi_resetn),
      .rd_req(rd_req),
      .rd_req_ready(rd_req_ready),
      .ram_raddr(ram_raddr),
      .ram_rdata(ram_rdata),
      .fwd_beat(fwd_beat),
      .fwd_valid(fwd_valid),
      .fwd_ready(fwd_ready),
      .m_axis_beat(m_axis_beat),
      .m_axis_tvalid(m_axis_tvalid),
      .m_axis_tready(m_axis_tready)
   );

endmodule

//--- hdl/read_responder.sv
// egress mux of read bursts and forwarded packets; the RAM is read as the burst drains, not at accept
`timescale 1ns/1ps

module read_responder (
   input  logic                  axi_aclk,
   input  logic                  axi_resetn,
   input  ualink_pkg::rd_req_t   rd_req,
   output logic                  rd_req_ready,
   output ualink_pkg::ram_addr_t ram_raddr,
   input  axis_pkg::data_t       ram_rdata,
   input  axis_pkg::axis_beat_t  fwd_beat,
   input  logic                  fwd_valid,
   output logic                  fwd_ready,
   output axis_pkg::axis_beat_t  m_axis_beat,
   output logic                  m_axis_tvalid,
   input  logic                  m_axis_tready
);
   import axis_pkg::*;
   import ualink_pkg::*;

   localparam int CNT_W = $clog2(BURST_WORDS + 1);

   typedef enum logic [1:0] {
      R_IDLE,
      R_FWD,
      R_BURST
   } state_t;

   state_t           state_q;
   state_t           state_d;
   axis_beat_t       out_q;        // egress output register
   logic             out_valid_q;
   logic             out_free;
   ram_addr_t        rd_addr_q;    // address of the next word to load
   logic [CNT_W-1:0] word_cnt_q;   // burst words loaded into out_q
   logic             data_ok_q;    // ram_rdata holds word word_cnt_q
   logic             last_word;
   logic             load_fwd;
   logic             load_ram;
   logic             rd_take;

   assign out_free  = !out_valid_q || m_axis_tready;
   assign last_word = (word_cnt_q == CNT_W'(BURST_WORDS - 1));
   assign rd_take   = rd_req.valid && rd_req_ready;

   // hold the address under stall so rdata keeps the pending word
   assign ram_raddr = load_ram ? ram_addr_t'(rd_addr_q + 1'b1) : rd_addr_q;

   assign m_axis_beat   = out_q;
   assign m_axis_tvalid = out_valid_q;

   always_comb begin
      state_d      = state_q;
      rd_req_ready = 1'b0;
      fwd_ready    = 1'b0;
      load_fwd     = 1'b0;
      load_ram     = 1'b0;
      case (state_q)
         R_IDLE: begin
            if (rd_req.valid) begin // request wins between packets
               rd_req_ready = 1'b1;
               state_d      = R_BURST;
            end else begin
               fwd_ready = out_free;
               if (fwd_valid && out_free) begin
                  load_fwd = 1'b1;
                  if (!fwd_beat.last) begin
                     state_d = R_FWD;
                  end
               end
            end
         end
         R_FWD: begin
            fwd_ready = out_free;
            if (fwd_valid && out_free) begin
               load_fwd = 1'b1;
               if (fwd_beat.last) begin
                  state_d = R_IDLE;
               end
            end
         end
         R_BURST: begin
            if (data_ok_q && out_free) begin
               load_ram = 1'b1;
               if (last_word) begin
                  state_d = R_IDLE;
               end
            end
         end
         default: state_d = R_IDLE;
      endcase
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         state_q     <= R_IDLE;
         out_valid_q <= 1'b0;
         data_ok_q   <= 1'b0;
         word_cnt_q  <= '0;
      end else begin
         state_q <= state_d;
         if (load_fwd || load_ram) begin
            out_valid_q <= 1'b1;
         end else if (m_axis_tready) begin
            out_valid_q <= 1'b0;
         end
         if (rd_take) begin
            word_cnt_q <= '0;
            data_ok_q  <= 1'b0; // first read is in flight
         end else if (state_q == R_BURST) begin
            data_ok_q <= !(load_ram && last_word);
            if (load_ram) begin
               word_cnt_q <= word_cnt_q + 1'b1;
            end
         end else begin
            data_ok_q <= 1'b0;
         end
      end
   end

   // payload path
   always_ff @(posedge axi_aclk) begin
      if (rd_take) begin
         rd_addr_q <= rd_req.addr;
      end else if (load_ram) begin
         rd_addr_q <= rd_addr_q + 1'b1;
      end
      if (load_fwd) begin
         out_q <= fwd_beat;
      end else if (load_ram) begin
         out_q <= '{data: ram_rdata, last: last_word};
      end
   end

endmodule

//--- hdl/cmd_ram.sv
// 256 x 64 command RAM; no reset, read of a word written on the same edge returns old data
`timescale 1ns/1ps

module cmd_ram (
   input  logic                  axi_aclk,
   input  logic                  we,
   input  ualink_pkg::ram_addr_t waddr,
   input  axis_pkg::data_t       wdata,
   input  ualink_pkg::ram_addr_t raddr,
   output axis_pkg::data_t       rdata
);
   import axis_pkg::*;
   import ualink_pkg::*;

   localparam int DEPTH = 2 ** $bits(ram_addr_t);

   data_t mem [DEPTH];

   // write port
   always_ff @(posedge axi_aclk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
   end

   // registered read, one cycle latency
   always_ff @(posedge axi_aclk) begin
      rdata <= mem[raddr];
   end

endmodule

//--- hdl/ualink_cmd_parser.sv
// header decoder; a write stores at most BURST_WORDS beats, extra beats and read payloads are dropped
`timescale 1ns/1ps

module ualink_cmd_parser (
   input  logic                  axi_aclk,
   input  logic                  axi_resetn,
   input  axis_pkg::axis_beat_t  fifo_beat,
   input  logic                  fifo_valid,
   output logic                  fifo_pop,
   output axis_pkg::axis_beat_t  fwd_beat,
   output logic                  fwd_valid,
   input  logic                  fwd_ready,
   output ualink_pkg::rd_req_t   rd_req,
   input  logic                  rd_req_ready,
   output logic                  ram_we,
   output ualink_pkg::ram_addr_t ram_waddr,
   output axis_pkg::data_t       ram_wdata
);
   import ualink_pkg::*;

   localparam int CNT_W = $clog2(BURST_WORDS + 1);

   typedef enum logic [2:0] {
      ST_HEADER,
      ST_WR_DATA,
      ST_RD_REQ,
      ST_RD_DRAIN,
      ST_FORWARD
   } state_t;

   state_t           state_q;
   state_t           state_d;
   opcode_t          hdr_op;
   ram_addr_t        hdr_addr;
   ram_addr_t        wr_addr_q;  // next RAM word of the write burst
   logic [CNT_W-1:0] wr_cnt_q;   // data beats stored so far
   ram_addr_t        rd_addr_q;
   logic             rd_last_q;  // read header was also the last beat
   logic             hdr_write;
   logic             hdr_read;

   // header fields are only meaningful in ST_HEADER
   assign hdr_op    = opcode_t'(fifo_beat.data[OPCODE_LSB +: $bits(opcode_t)]);
   assign hdr_addr  = fifo_beat.data[ADDR_LSB +: $bits(ram_addr_t)];
   assign hdr_write = (hdr_op == OP_WRITE);
   assign hdr_read  = (hdr_op == OP_READ);

   // other packets pass straight through from the FIFO head
   assign fwd_beat  = fifo_beat;

   assign ram_waddr = wr_addr_q;
   assign ram_wdata = fifo_beat.data;

   // request stays up until the responder takes it
   assign rd_req = '{valid: (state_q == ST_RD_REQ), addr: rd_addr_q};

   always_comb begin
      state_d   = state_q;
      fifo_pop  = 1'b0;
      fwd_valid = 1'b0;
      ram_we    = 1'b0;
      case (state_q)
         ST_HEADER: begin
            if (fifo_valid) begin
               if (hdr_write) begin
                  fifo_pop = 1'b1;
                  if (!fifo_beat.last) begin
                     state_d = ST_WR_DATA;
                  end
               end else if (hdr_read) begin
                  fifo_pop = 1'b1;
                  state_d  = ST_RD_REQ;
               end else begin
                  fwd_valid = 1'b1; // header is part of the forwarded packet
                  if (fwd_ready) begin
                     fifo_pop = 1'b1;
                     if (!fifo_beat.last) begin
                        state_d = ST_FORWARD;
                     end
                  end
               end
            end
         end
         ST_WR_DATA: begin
            if (fifo_valid) begin
               fifo_pop = 1'b1;
               ram_we   = (wr_cnt_q < CNT_W'(BURST_WORDS)); // beyond the burst is dropped
               if (fifo_beat.last) begin
                  state_d = ST_HEADER;
               end
            end
         end
         ST_RD_REQ: begin
            if (rd_req_ready) begin
               state_d = rd_last_q ? ST_HEADER : ST_RD_DRAIN;
            end
         end
         ST_RD_DRAIN: begin
            if (fifo_valid) begin
               fifo_pop = 1'b1;
               if (fifo_beat.last) begin
                  state_d = ST_HEADER;
               end
            end
         end
         ST_FORWARD: begin
            fwd_valid = fifo_valid;
            if (fifo_valid && fwd_ready) begin
               fifo_pop = 1'b1;
               if (fifo_beat.last) begin
                  state_d = ST_HEADER;
               end
            end
         end
         default: state_d = ST_HEADER;
      endcase
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         state_q  <= ST_HEADER;
         wr_cnt_q <= '0;
      end else begin
         state_q <= state_d;
         if (state_q == ST_HEADER && fifo_pop && hdr_write) begin
            wr_cnt_q <= '0;
         end else if (ram_we) begin
            wr_cnt_q <= wr_cnt_q + 1'b1;
         end
      end
   end

   // addresses latched from the header
   always_ff @(posedge axi_aclk) begin
      if (state_q == ST_HEADER && fifo_pop) begin
         wr_addr_q <= hdr_addr;
         rd_addr_q <= hdr_addr;
         rd_last_q <= fifo_beat.last;
      end else if (ram_we) begin
         wr_addr_q <= wr_addr_q + 1'b1; // wraps at 256
      end
   end

endmodule

//--- hdl/ingress_fifo.sv
// fall-through beat FIFO; needs FIFO_DEPTH_BITS >= 2, nearly_full flags two or fewer free entries
`timescale 1ns/1ps

module ingress_fifo #(
   parameter int FIFO_DEPTH_BITS = 4
) (
   input  logic                 axi_aclk,
   input  logic                 axi_resetn,
   input  axis_pkg::axis_beat_t wr_beat,
   input  logic                 wr_valid,
   output logic                 nearly_full,
   output axis_pkg::axis_beat_t rd_beat,
   output logic                 rd_valid,
   input  logic                 rd_pop
);
   import axis_pkg::*;

   localparam int DEPTH = 1 << FIFO_DEPTH_BITS;

   axis_beat_t                 mem [DEPTH];
   logic [FIFO_DEPTH_BITS-1:0] wr_ptr;
   logic [FIFO_DEPTH_BITS-1:0] rd_ptr;
   logic [FIFO_DEPTH_BITS:0]   count; // occupancy, one bit wider than the pointers
   logic                       do_wr;
   logic                       do_rd;

   assign do_wr = wr_valid && !nearly_full; // source sees ready as ~nearly_full
   assign do_rd = rd_pop && rd_valid;

   // head entry shown without a read cycle
   assign rd_valid = (count != '0);
   assign rd_beat  = mem[rd_ptr];

   // keeps two slots of slack behind ready
   assign nearly_full = (count >= (FIFO_DEPTH_BITS + 1)'(DEPTH - 2));

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count; // idle or push and pop together
         endcase
      end
   end

   // storage
   always_ff @(posedge axi_aclk) begin
      if (do_wr) begin
         mem[wr_ptr] <= wr_beat;
      end
   end

endmodule

//--- hdl/ualink_pkg.sv
// command header layout for the 64-bit endpoint; the RAM address wraps at 256 words
package ualink_pkg;

   // opcode field of the header word, bits 63 to 48
   typedef enum logic [15:0] {
      OP_READ  = 16'h0145,
      OP_WRITE = 16'h0245
   } opcode_t;

   typedef logic [7:0] ram_addr_t; // command RAM word address

   localparam int BURST_WORDS = 8; // data words per write or read burst

   // header field positions
   localparam int OPCODE_LSB = 48;
   localparam int ADDR_LSB   = 0;

   // read request from parser to responder
   typedef struct packed {
      logic      valid;
      ram_addr_t addr; // first word of the burst
   } rd_req_t;

endpackage

//--- hdl/axis_pkg.sv
// 64-bit stream beat types; tstrb and tuser are not carried, every beat is a full word
package axis_pkg;

   typedef logic [63:0] data_t; // one stream data word

   // one beat on any stream port of the endpoint
   typedef struct packed {
      data_t data;
      logic  last; // end of packet
   } axis_beat_t;

endpackage
